//--- src.f
+incdir+tests
design/hdr_pkg.sv
design/header_remover.sv
design/header_rewriter.sv
design/header_adder.sv
design/hdr_rewrite_top.sv
tests/tb_hdr_rewrite.sv

//--- Makefile
SIM := obj_dir/Vtb_hdr_rewrite

.PHONY: all run clean

all: run

$(SIM): src.f $(wildcard design/*.sv tests/*.sv tests/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_hdr_rewrite

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'Simulation passed'

clean:
	rm -rf obj_dir

//--- tests/tb_ref.svh
// ------------------------------
// Reference model of the header rewrite
// Expected bytes and tdest of one packet
// ------------------------------
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef logic [7:0] byte_q_t [$];

// Route headers take their port from the table, stamp headers count one more hop
function automatic hdr_word_u rewrite_header(input hdr_word_u hdr,
                                            input logic [7:0] tbl [FLOW_COUNT]);
  hdr_word_u res;
  res = hdr;
  if (hdr.route.kind == HDR_ROUTE) begin
    res.route.dest = tbl[hdr.route.flow_id[3:0]];
  end else if (hdr.stamp.hop_count < 8'hff) begin
    res.stamp.hop_count = hdr.stamp.hop_count + 8'd1;
  end
  return res;
endfunction

// The header sits in bytes 0 to 3, least significant byte first
function automatic byte_q_t expected_bytes(input byte_q_t pkt, input logic has_hdr,
                                           input logic [7:0] tbl [FLOW_COUNT]);
  byte_q_t     res;
  logic [31:0] word;
  res = pkt;
  if (has_hdr) begin
    word = {pkt[3], pkt[2], pkt[1], pkt[0]};
    word = rewrite_header(word, tbl);
    for (int i = 0; i < 4; i++) begin
      res[i] = word[8*i +: 8];
    end
  end
  return res;
endfunction

function automatic logic [7:0] expected_dest(input byte_q_t pkt, input logic has_hdr,
                                             input logic [7:0] in_dest,
                                             input logic [7:0] tbl [FLOW_COUNT]);
  hdr_word_u hdr;
  hdr = {pkt[3], pkt[2], pkt[1], pkt[0]};
  if (has_hdr && hdr.route.kind == HDR_ROUTE) begin
    return tbl[hdr.route.flow_id[3:0]];
  end
  return in_dest;
endfunction

`endif

//--- tests/tb_hdr_rewrite.sv
// ------------------------------
// Testbench for the header rewrite subsystem
// Random packets checked against a byte-level reference
// ------------------------------
`timescale 1ns/1ps

module tb_hdr_rewrite import hdr_pkg::*; ();

  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int FLOW_COUNT = 16;
  localparam int N_PKTS     = 20;
  localparam int N_SWEEP    = 37;
  localparam int N_STRESS   = 60;
  localparam int MAX_BEATS  = 5;
  localparam int TOTAL_PKTS = 3 * N_PKTS + N_SWEEP + N_STRESS;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [DATA_WIDTH-1:0] in_tdata;
  logic [STRB_WIDTH-1:0] in_tkeep;
  logic [7:0]            in_tdest;
  logic                  in_tlast;
  logic                  in_tvalid;
  logic                  in_has_hdr;
  logic                  in_tready;
  logic [DATA_WIDTH-1:0] out_tdata;
  logic [STRB_WIDTH-1:0] out_tkeep;
  logic [7:0]            out_tdest;
  logic                  out_tlast;
  logic                  out_tvalid;
  logic                  out_tready;
  cfg_wr_t               cfg;

  logic [31:0] lfsr = 32'h02cd_8f8f;
  logic [7:0]  shadow_tbl [FLOW_COUNT];
  logic [7:0]  got_q [$];
  logic [7:0]  exp_bytes_q [$];
  int          exp_len_q [$];
  logic [7:0]  exp_dest_q [$];
  logic        stall_en = 1'b0;
  logic        next_ready = 1'b1;
  int          err_count = 0;
  int          test_count = 0;
  int          failed_tests = 0;

  `include "tb_ref.svh"

  hdr_rewrite_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEST_WIDTH (8),
    .FLOW_COUNT (FLOW_COUNT)
  ) hdr_rewrite_top_i (.*);

  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // Stall choice is made at the falling edge and driven after the rising one
  always @(negedge clk) begin
    next_ready = stall_en ? (random_bits(2) != 0) : 1'b1;
  end

  always begin
    @(posedge clk);
    #1;
    out_tready = next_ready;
  end

  function automatic void check_packet();
    int         exp_len;
    logic [7:0] exp_dest;
    logic [7:0] exp_byte;
    logic       mismatch;
    if (exp_len_q.size() == 0) begin
      $display("Unexpected output packet of %0d bytes at %0t", got_q.size(), $time);
      err_count++;
    end else begin
      exp_len  = exp_len_q.pop_front();
      exp_dest = exp_dest_q.pop_front();
      mismatch = 1'b0;
      if (got_q.size() != exp_len) begin
        $display("error at %0t: packet has %0d bytes, expected %0d", $time, got_q.size(),
                 exp_len);
        err_count++;
      end
      for (int i = 0; i < exp_len; i++) begin
        exp_byte = exp_bytes_q.pop_front();
        if (!mismatch && i < got_q.size() && got_q[i] !== exp_byte) begin
          $display("error at %0t: byte %0d is %02h, expected %02h", $time, i, got_q[i],
                   exp_byte);
          mismatch = 1'b1;
          err_count++;
        end
      end
      if (out_tdest !== exp_dest) begin
        $display("error at %0t: tdest is %02h, expected %02h", $time, out_tdest, exp_dest);
        err_count++;
      end
    end
    got_q.delete();
  endfunction

  // Output beats are taken at the falling edge, where the handshake is settled
  always @(negedge clk) begin
    if (!rst && out_tvalid && out_tready) begin
      for (int k = 0; k < STRB_WIDTH; k++) begin
        if (out_tkeep[k]) begin
          got_q.push_back(out_tdata[8*k +: 8]);
        end
      end
      if (out_tlast) begin
        check_packet();
      end
    end
  end

  task automatic send_packet(input byte_q_t pkt, input logic has_hdr,
                             input logic [7:0] dest, input logic gaps);
    int   nbeats;
    int   idx;
    logic accepted;
    nbeats = (pkt.size() + STRB_WIDTH - 1) / STRB_WIDTH;
    for (int b = 0; b < nbeats; b++) begin
      if (gaps) begin
        in_tvalid = 1'b0;
        repeat (int'(random_bits(2))) begin
          @(posedge clk);
          #1;
        end
      end
      in_tdata = '0;
      in_tkeep = '0;
      for (int k = 0; k < STRB_WIDTH; k++) begin
        idx = b * STRB_WIDTH + k;
        if (idx < pkt.size()) begin
          in_tdata[8*k +: 8] = pkt[idx];
          in_tkeep[k]        = 1'b1;
        end
      end
      in_tdest   = dest;
      in_tlast   = (b == nbeats - 1);
      in_has_hdr = has_hdr;
      in_tvalid  = 1'b1;
      accepted   = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = in_tready;
        @(posedge clk);
        #1;
      end
    end
    in_tvalid = 1'b0;
  endtask

  task automatic report_test(input string name, input int count, input int errs_before);
    test_count++;
    if (err_count != errs_before) begin
      failed_tests++;
      $display("test %s: failed, %0d packets", name, count);
    end else begin
      $display("test %s: ok, %0d packets", name, count);
    end
  endtask

  // Kind 0 is route, 1 is stamp, 2 has no header; mode 3 mixes all three
  task automatic run_test(input string name, input int mode, input int count,
                          input logic sweep, input logic stress);
    byte_q_t     pkt;
    byte_q_t     exp;
    hdr_word_u   hdr;
    logic [31:0] hdr_bits;
    logic [7:0]  dest;
    int          len;
    int          kind;
    int          errs_before;
    errs_before = err_count;
    stall_en    = stress;
    for (int n = 0; n < count; n++) begin
      len  = sweep ? 4 + n : 4 + int'(random_bits(6) % 37);
      kind = (mode == 3) ? int'(random_bits(2) % 3) : mode;
      hdr  = '0;
      if (kind == 0) begin
        hdr.route.kind    = HDR_ROUTE;
        hdr.route.flow_id = 8'(random_bits(4));
        hdr.route.dest    = 8'(random_bits(8));
        hdr.route.length  = 15'(len);
      end else if (kind == 1) begin
        hdr.stamp.kind      = HDR_STAMP;
        hdr.stamp.hop_count = (random_bits(2) == 0) ? 8'hff : 8'(random_bits(8));
        hdr.stamp.stamp     = 23'(random_bits(23));
      end
      hdr_bits = hdr;
      pkt.delete();
      for (int i = 0; i < len; i++) begin
        pkt.push_back((kind != 2 && i < 4) ? hdr_bits[8*i +: 8] : 8'(random_bits(8)));
      end
      dest = 8'(random_bits(8));
      exp  = expected_bytes(pkt, kind != 2, shadow_tbl);
      foreach (exp[i]) begin
        exp_bytes_q.push_back(exp[i]);
      end
      exp_len_q.push_back(exp.size());
      exp_dest_q.push_back(expected_dest(pkt, kind != 2, dest, shadow_tbl));
      send_packet(pkt, kind != 2, dest, stress);
    end
    while (exp_len_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    stall_en = 1'b0;
    report_test(name, count, errs_before);
  endtask

  initial begin
    int idle_errs;
    rst        = 1'b1;
    in_tdata   = '0;
    in_tkeep   = '0;
    in_tdest   = '0;
    in_tlast   = 1'b0;
    in_tvalid  = 1'b0;
    in_has_hdr = 1'b0;
    out_tready = 1'b1;
    cfg        = '0;
    repeat (16) @(posedge clk);
    #1;
    rst       = 1'b0;
    idle_errs = err_count;
    repeat (10) begin
      @(negedge clk);
      if (out_tvalid !== 1'b0) begin
        $display("error at %0t: out_tvalid is high with no input", $time);
        err_count++;
      end
    end
    @(posedge clk);
    #1;
    report_test("idle", 0, idle_errs);
    // Every flow gets its own port before any packet is sent
    for (int f = 0; f < FLOW_COUNT; f++) begin
      shadow_tbl[f] = 8'(random_bits(8));
      cfg.en        = 1'b1;
      cfg.flow_id   = 8'(f);
      cfg.port      = shadow_tbl[f];
      @(posedge clk);
      #1;
    end
    cfg.en = 1'b0;
    run_test("route", 0, N_PKTS, 1'b0, 1'b0);
    run_test("stamp", 1, N_PKTS, 1'b0, 1'b0);
    run_test("no header", 2, N_PKTS, 1'b0, 1'b0);
    run_test("lengths", 3, N_SWEEP, 1'b1, 1'b0);
    run_test("stalls", 3, N_STRESS, 1'b0, 1'b1);
    if (got_q.size() != 0) begin
      $display("Output ended with %0d bytes that never saw tlast", got_q.size());
      err_count++;
    end
    $display("tests run: %0d, tests failed: %0d, errors: %0d", test_count, failed_tests,
             err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Each beat of each packet is allowed 40 cycles
  initial begin
    repeat (TOTAL_PKTS * MAX_BEATS * 40 + 200) @(posedge clk);
    $display("Timeout: the packets did not all come out of the DUT in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- design/hdr_rewrite_top.sv
// ----------------------------
// Header rewrite subsystem
// Remove, rewrite and re-insert the header of each packet
// ----------------------------
`timescale 1ns/1ps

module hdr_rewrite_top import hdr_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int DEST_WIDTH = 8,
  parameter int FLOW_COUNT = 16
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic [DATA_WIDTH-1:0]   in_tdata,
  input  logic [DATA_WIDTH/8-1:0] in_tkeep,
  input  logic [DEST_WIDTH-1:0]   in_tdest,
  input  logic                    in_tlast,
  input  logic                    in_tvalid,
  input  logic                    in_has_hdr,
  output logic                    in_tready,

  output logic [DATA_WIDTH-1:0]   out_tdata,
  output logic [DATA_WIDTH/8-1:0] out_tkeep,
  output logic [DEST_WIDTH-1:0]   out_tdest,
  output logic                    out_tlast,
  output logic                    out_tvalid,
  input  logic                    out_tready,

  input  cfg_wr_t                 cfg
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mid_tdata;
  logic [STRB_WIDTH-1:0] mid_tkeep;
  logic [DEST_WIDTH-1:0] mid_tdest;
  logic                  mid_tlast;
  logic                  mid_tvalid;
  logic                  mid_tready;

  hdr_word_u             rm_header;
  logic                  rm_header_valid;
  hdr_word_u             new_header;
  logic                  new_header_valid;
  logic [DEST_WIDTH-1:0] new_dest;
  logic                  dest_override;
  logic [DEST_WIDTH-1:0] add_tdest;

  header_remover #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEST_WIDTH (DEST_WIDTH)
  ) header_remover_i (
    .clk          (clk),
    .rst          (rst),
    .has_header   (in_has_hdr),
    .s_tdata      (in_tdata),
    .s_tkeep      (in_tkeep),
    .s_tdest      (in_tdest),
    .s_tlast      (in_tlast),
    .s_tvalid     (in_tvalid),
    .s_tready     (in_tready),
    .header       (rm_header),
    .header_valid (rm_header_valid),
    .m_tdata      (mid_tdata),
    .m_tkeep      (mid_tkeep),
    .m_tdest      (mid_tdest),
    .m_tlast      (mid_tlast),
    .m_tvalid     (mid_tvalid),
    .m_tready     (mid_tready)
  );

  header_rewriter #(
    .DEST_WIDTH (DEST_WIDTH),
    .FLOW_COUNT (FLOW_COUNT)
  ) header_rewriter_i (
    .clk              (clk),
    .rst              (rst),
    .cfg              (cfg),
    .header           (rm_header),
    .header_valid     (rm_header_valid),
    .new_header       (new_header),
    .new_header_valid (new_header_valid),
    .new_dest         (new_dest),
    .dest_override    (dest_override)
  );

  // Route packets leave on the port from the flow table
  assign add_tdest = dest_override ? new_dest : mid_tdest;

  header_adder #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEST_WIDTH (DEST_WIDTH)
  ) header_adder_i (
    .clk          (clk),
    .rst          (rst),
    .s_tdata      (mid_tdata),
    .s_tkeep      (mid_tkeep),
    .s_tdest      (add_tdest),
    .s_tlast      (mid_tlast),
    .s_tvalid     (mid_tvalid),
    .s_tready     (mid_tready),
    .header       (new_header),
    .header_valid (new_header_valid),
    .m_tdata      (out_tdata),
    .m_tkeep      (out_tkeep),
    .m_tdest      (out_tdest),
    .m_tlast      (out_tlast),
    .m_tvalid     (out_tvalid),
    .m_tready     (out_tready)
  );

endmodule

//--- design/header_adder.sv
// ----------------------------
// Header adder
// Inserts a header and shifts the payload up by four bytes
// ----------------------------
`timescale 1ns/1ps

module header_adder import hdr_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int DEST_WIDTH = 8
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic [DATA_WIDTH-1:0]   s_tdata,
  input  logic [DATA_WIDTH/8-1:0] s_tkeep,
  input  logic [DEST_WIDTH-1:0]   s_tdest,
  input  logic                    s_tlast,
  input  logic                    s_tvalid,
  output logic                    s_tready,

  input  hdr_word_u               header,
  input  logic                    header_valid,

  output logic [DATA_WIDTH-1:0]   m_tdata,
  output logic [DATA_WIDTH/8-1:0] m_tkeep,
  output logic [DEST_WIDTH-1:0]   m_tdest,
  output logic                    m_tlast,
  output logic                    m_tvalid,
  input  logic                    m_tready
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int LOW_BITS   = DATA_WIDTH - HDR_BITS;
  localparam int LOW_BYTES  = STRB_WIDTH - HDR_BYTES;

  pkt_state_e            state;
  logic [HDR_BITS-1:0]   rest_tdata;
  logic [HDR_BYTES-1:0]  rest_tkeep;
  logic [DEST_WIDTH-1:0] tdest_r;
  logic                  strb_left;
  logic                  s_fire;

  // Top four bytes get pushed out of the beat by the shift
  assign strb_left = |s_tkeep[STRB_WIDTH-1:LOW_BYTES];
  assign s_fire    = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else if (s_fire) begin
      case (state)
        ST_HDR: begin
          if (s_tlast) begin
            state <= (header_valid && strb_left) ? ST_LST : ST_HDR;
          end else begin
            state <= header_valid ? ST_MID : ST_FWD;
          end
        end
        ST_MID: begin
          if (s_tlast) begin
            state <= strb_left ? ST_LST : ST_HDR;
          end
        end
        ST_FWD: begin
          if (s_tlast) begin
            state <= ST_HDR;
          end
        end
        default: begin
        end
      endcase
    end else if (state == ST_LST && m_tready) begin
      state <= ST_HDR;
    end
  end

  // Displaced upper bytes are held for the following output beat
  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_tdata <= s_tdata[DATA_WIDTH-1:LOW_BITS];
      rest_tkeep <= s_tkeep[STRB_WIDTH-1:LOW_BYTES];
      if (state == ST_HDR) begin
        tdest_r <= s_tdest;
      end
    end
  end

  assign m_tdest  = (state == ST_HDR) ? s_tdest : tdest_r;
  assign m_tvalid = (state == ST_LST) ? 1'b1 : s_tvalid;
  assign s_tready = (state == ST_LST) ? 1'b0 : m_tready;

  always_comb begin
    m_tdata = s_tdata;
    m_tkeep = s_tkeep;
    m_tlast = s_tlast;
    case (state)
      ST_HDR: begin
        if (header_valid) begin
          m_tdata = {s_tdata[LOW_BITS-1:0], header};
          m_tkeep = {s_tkeep[LOW_BYTES-1:0], {HDR_BYTES{1'b1}}};
          m_tlast = s_tlast && !strb_left;
        end
      end
      ST_MID: begin
        m_tdata = {s_tdata[LOW_BITS-1:0], rest_tdata};
        m_tkeep = {s_tkeep[LOW_BYTES-1:0], rest_tkeep};
        m_tlast = s_tlast && !strb_left;
      end
      ST_LST: begin
        m_tdata = {{LOW_BITS{1'b0}}, rest_tdata};
        m_tkeep = {{LOW_BYTES{1'b0}}, rest_tkeep};
        m_tlast = 1'b1;
      end
      default: begin
        // Plain forwarding when no header came with the packet
      end
    endcase
  end

  // Upstream is held off while leftover bytes drain and at least one byte is left
  a_lst_stall: assert property (@(posedge clk) disable iff (rst)
    state == ST_LST |-> !s_tready && m_tkeep != '0);

endmodule

//--- design/header_rewriter.sv
// ----------------------------
// Header rewriter
// Route lookup from the flow table and hop count update
// ----------------------------
`timescale 1ns/1ps

module header_rewriter import hdr_pkg::*; #(
  parameter int DEST_WIDTH = 8,
  parameter int FLOW_COUNT = 16
) (
  input  logic                  clk,
  input  logic                  rst,

  input  cfg_wr_t               cfg,

  input  hdr_word_u             header,
  input  logic                  header_valid,

  output hdr_word_u             new_header,
  output logic                  new_header_valid,
  output logic [DEST_WIDTH-1:0] new_dest,
  output logic                  dest_override
);

  localparam int IDX_W = $clog2(FLOW_COUNT);

  logic [7:0] route_tbl [FLOW_COUNT];
  logic [7:0] route_port;
  logic       is_route;

  // Table writes become visible one cycle after cfg.en
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FLOW_COUNT; i++) begin
        route_tbl[i] <= 8'd0;
      end
    end else if (cfg.en && cfg.flow_id < FLOW_COUNT) begin
      route_tbl[cfg.flow_id[IDX_W-1:0]] <= cfg.port;
    end
  end

  assign is_route   = header.route.kind == HDR_ROUTE;
  assign route_port = route_tbl[header.route.flow_id[IDX_W-1:0]];

  always_comb begin
    new_header = header;
    if (is_route) begin
      new_header.route.dest = route_port;
    end else if (header.stamp.hop_count != 8'hff) begin
      // Hop count saturates at 255
      new_header.stamp.hop_count = header.stamp.hop_count + 8'd1;
    end
  end

  assign new_header_valid = header_valid;
  assign new_dest         = DEST_WIDTH'(route_port);
  assign dest_override    = header_valid && is_route;

  // Flow ids from the upstream stream must index an existing entry
  a_flow_range: assert property (@(posedge clk) disable iff (rst)
    header_valid && is_route |-> header.route.flow_id < FLOW_COUNT);

endmodule

//--- design/header_remover.sv
// ----------------------------
// Header remover
// Strips the 32-bit header and shifts the payload down by four bytes
// ----------------------------
`timescale 1ns/1ps

module header_remover import hdr_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int DEST_WIDTH = 8
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic                    has_header,

  input  logic [DATA_WIDTH-1:0]   s_tdata,
  input  logic [DATA_WIDTH/8-1:0] s_tkeep,
  input  logic [DEST_WIDTH-1:0]   s_tdest,
  input  logic                    s_tlast,
  input  logic                    s_tvalid,
  output logic                    s_tready,

  output hdr_word_u               header,
  output logic                    header_valid,

  output logic [DATA_WIDTH-1:0]   m_tdata,
  output logic [DATA_WIDTH/8-1:0] m_tkeep,
  output logic [DEST_WIDTH-1:0]   m_tdest,
  output logic                    m_tlast,
  output logic                    m_tvalid,
  input  logic                    m_tready
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int REST_BITS  = DATA_WIDTH - HDR_BITS;
  localparam int REST_BYTES = STRB_WIDTH - HDR_BYTES;

  pkt_state_e            state;
  hdr_word_u             header_r;
  logic [REST_BITS-1:0]  rest_tdata;
  logic [REST_BYTES-1:0] rest_tkeep;
  logic [DEST_WIDTH-1:0] tdest_r;
  logic                  strb_left;
  logic                  s_fire;

  // Bytes above the header slot still have to go out after this beat
  assign strb_left = |s_tkeep[STRB_WIDTH-1:HDR_BYTES];
  assign s_fire    = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else if (s_fire) begin
      case (state)
        ST_HDR: begin
          // A single-beat packet leaves in this same cycle
          if (!s_tlast) begin
            state <= has_header ? ST_MID : ST_FWD;
          end
        end
        ST_MID: begin
          if (s_tlast) begin
            state <= strb_left ? ST_LST : ST_HDR;
          end
        end
        ST_FWD: begin
          if (s_tlast) begin
            state <= ST_HDR;
          end
        end
        default: begin
        end
      endcase
    end else if (state == ST_LST && m_tready) begin
      state <= ST_HDR;
    end
  end

  // Upper bytes of every accepted beat wait for the low bytes of the next one
  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_tdata <= s_tdata[DATA_WIDTH-1:HDR_BITS];
      rest_tkeep <= s_tkeep[STRB_WIDTH-1:HDR_BYTES];
      if (state == ST_HDR) begin
        header_r <= s_tdata[HDR_BITS-1:0];
        tdest_r  <= s_tdest;
      end
    end
  end

  assign header       = (state == ST_HDR) ? s_tdata[HDR_BITS-1:0] : header_r;
  assign header_valid = (state == ST_HDR && has_header && s_tvalid) ||
                        state == ST_MID || state == ST_LST;
  assign m_tdest      = (state == ST_HDR) ? s_tdest : tdest_r;

  always_comb begin
    m_tdata  = s_tdata;
    m_tkeep  = s_tkeep;
    m_tlast  = s_tlast;
    m_tvalid = s_tvalid;
    s_tready = m_tready;
    case (state)
      ST_HDR: begin
        if (has_header) begin
          // The first beat only produces output when it is also the last
          m_tdata  = {{HDR_BITS{1'b0}}, s_tdata[DATA_WIDTH-1:HDR_BITS]};
          m_tkeep  = {{HDR_BYTES{1'b0}}, s_tkeep[STRB_WIDTH-1:HDR_BYTES]};
          m_tvalid = s_tvalid && s_tlast;
          s_tready = s_tlast ? m_tready : 1'b1;
        end
      end
      ST_MID: begin
        m_tdata = {s_tdata[HDR_BITS-1:0], rest_tdata};
        m_tkeep = {s_tkeep[HDR_BYTES-1:0], rest_tkeep};
        m_tlast = s_tlast && !strb_left;
      end
      ST_LST: begin
        m_tdata  = {{HDR_BITS{1'b0}}, rest_tdata};
        m_tkeep  = {{HDR_BYTES{1'b0}}, rest_tkeep};
        m_tlast  = 1'b1;
        m_tvalid = 1'b1;
        s_tready = 1'b0;
      end
      default: begin
        // Packets without a header go through untouched
      end
    endcase
  end

  // The trailing beat is only entered with upper bytes still to send
  a_lst_valid: assert property (@(posedge clk) disable iff (rst)
    state == ST_LST |-> m_tvalid && m_tkeep != '0);

endmodule

//--- design/hdr_pkg.sv
// ----------------------------
// Header rewrite definitions
// Header views, config write word and packet FSM states
// ----------------------------
package hdr_pkg;

  // The header format is fixed at one 32-bit word
  localparam int HDR_BITS  = 32;
  localparam int HDR_BYTES = HDR_BITS / 8;

  // Bit 31 of every header selects how the rest is decoded
  typedef enum logic {
    HDR_ROUTE = 1'b0,
    HDR_STAMP = 1'b1
  } hdr_kind_e;

  typedef struct packed {
    hdr_kind_e   kind;
    logic [7:0]  flow_id;
    logic [7:0]  dest;
    logic [14:0] length;
  } hdr_route_t;

  typedef struct packed {
    hdr_kind_e   kind;
    logic [7:0]  hop_count;
    logic [22:0] stamp;
  } hdr_stamp_t;

  // Same 32 bits, two decodings chosen by the kind bit
  typedef union packed {
    hdr_route_t route;
    hdr_stamp_t stamp;
  } hdr_word_u;

  // One route table write, taken when en is high
  typedef struct packed {
    logic       en;
    logic [7:0] flow_id;
    logic [7:0] port;
  } cfg_wr_t;

  // Per-packet states shared by the remover and the adder
  typedef enum logic [1:0] {
    ST_HDR = 2'b00,
    ST_MID = 2'b01,
    ST_LST = 2'b10,
    ST_FWD = 2'b11
  } pkt_state_e;

endpackage
